// File: common/mmu_pkg.sv
/*
 * Sv32 MMU shared definitions
 * widths, TLB geometry, PTE and satp layouts,
 * request/response structs and state encodings
 */
`default_nettype none

package mmu_pkg;

    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_BITS         = 20;
    localparam int PPN_BITS         = 22;
    localparam int ASID_BITS        = 9;

    localparam int TLB_SETS = 16;
    localparam int TLB_WAYS = 2;
    localparam int SET_BITS = (TLB_SETS > 1) ? $clog2(TLB_SETS) : 1;
    localparam int WAY_BITS = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1;
    localparam int TAG_BITS = VPN_BITS - SET_BITS;

    typedef logic [31:0]                          word_t;
    typedef logic [VPN_BITS-1:0]                  vpn_t;
    typedef logic [PPN_BITS-1:0]                  ppn_t;
    typedef logic [PPN_BITS+PAGE_OFFSET_BITS-1:0] paddr_t;   // 34 bits
    typedef logic [ASID_BITS-1:0]                 asid_t;
    typedef logic [SET_BITS-1:0]                  set_idx_t;
    typedef logic [WAY_BITS-1:0]                  way_idx_t;
    typedef logic [TAG_BITS-1:0]                  tag_t;

    // low 10 bits of an Sv32 PTE, msb first
    typedef struct packed {
        logic [1:0] reserved;
        logic       dirty;
        logic       accessed;
        logic       global_page;
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    typedef struct packed {
        ppn_t       ppn;
        pte_perms_t perms;
    } pte_t;

    typedef struct packed {
        logic  mode;    // 1 = Sv32, 0 = bare
        asid_t asid;
        ppn_t  ppn;     // root table
    } satp_t;

    typedef struct packed {
        logic  valid;
        asid_t asid;
        tag_t  tag;
        pte_t  pte;
    } tlb_entry_t;

    typedef tlb_entry_t [TLB_WAYS-1:0] tlb_set_t;

    typedef struct packed {
        word_t vaddr;
        logic  ren;
        logic  wen;
        logic  fetch;
    } tlb_req_t;

    typedef struct packed {
        paddr_t paddr;
        logic   busy;
        logic   fault_load;
        logic   fault_store;
        logic   fault_insn;
    } tlb_rsp_t;

    typedef struct packed {
        logic  fence;
        word_t va;      // zero means all pages
        asid_t asid;    // zero means all address spaces
    } fence_req_t;

    // position of the clear / fence sweep
    typedef struct packed {
        set_idx_t set_num;
        way_idx_t way_num;
    } sweep_idx_t;

    typedef enum logic [1:0] {NONE, LOAD, STORE, INSN} access_t;
    typedef enum logic [1:0] {CLEAR, LOOKUP, FILL, FENCE} tlb_state_t;
    typedef enum logic {IDLE, READ} fetch_state_t;

endpackage

`default_nettype wire

// File: tlb/tlb.sv
/*
 * Sv32 translation lookaside buffer
 * set-associative lookup with same-cycle hit, miss fill through
 * the PTE fetch unit, round-robin victim per set, and the
 * reset clear and fence sweeps
 */
`timescale 1ns/1ps
`default_nettype none

module tlb (
    input  logic                 CLK,
    input  logic                 nRST,
    input  mmu_pkg::tlb_req_t    req,
    input  mmu_pkg::satp_t       satp,
    input  logic                 user_mode,
    input  mmu_pkg::fence_req_t  fence,
    input  logic                 fill_valid,
    input  mmu_pkg::pte_t        fill_pte,
    output mmu_pkg::tlb_rsp_t    rsp,
    output logic                 fence_done,
    output logic                 fetch_start,
    output mmu_pkg::vpn_t        fetch_vpn
);

    mmu_pkg::tlb_state_t state, next_state;
    mmu_pkg::sweep_idx_t sweep_idx;
    logic                sweep_last;
    mmu_pkg::way_idx_t   victim [mmu_pkg::TLB_SETS];

    mmu_pkg::vpn_t       req_vpn;
    mmu_pkg::vpn_t       miss_vpn;
    mmu_pkg::set_idx_t   miss_set;
    mmu_pkg::word_t      fence_va_q;
    mmu_pkg::asid_t      fence_asid_q;

    mmu_pkg::set_idx_t   sram_index;
    mmu_pkg::tlb_set_t   sram_rdata;
    mmu_pkg::tlb_set_t   sram_wdata;
    logic                sram_wen;
    logic [mmu_pkg::TLB_WAYS-1:0] sram_wmask;

    logic                trans_on;
    logic                any_req;
    logic                hit;
    logic                miss;
    logic                check;
    mmu_pkg::pte_t       hit_pte;
    mmu_pkg::access_t    access;
    mmu_pkg::tlb_entry_t sweep_entry;
    mmu_pkg::tlb_entry_t fill_entry;
    logic                fence_match;

    assign req_vpn  = req.vaddr[31:mmu_pkg::PAGE_OFFSET_BITS];
    assign miss_set = miss_vpn[mmu_pkg::SET_BITS-1:0];
    assign trans_on = satp.mode;
    assign any_req  = req.ren | req.wen | req.fetch;

    assign access = req.wen   ? mmu_pkg::STORE :
                    req.ren   ? mmu_pkg::LOAD  :
                    req.fetch ? mmu_pkg::INSN  : mmu_pkg::NONE;

    assign sweep_last = (sweep_idx.set_num == mmu_pkg::set_idx_t'(mmu_pkg::TLB_SETS - 1))
                     && (sweep_idx.way_num == mmu_pkg::way_idx_t'(mmu_pkg::TLB_WAYS - 1));

    always_comb begin
        case (state)
            mmu_pkg::CLEAR,
            mmu_pkg::FENCE: sram_index = sweep_idx.set_num;
            mmu_pkg::FILL:  sram_index = miss_set;
            default:        sram_index = req_vpn[mmu_pkg::SET_BITS-1:0];
        endcase
    end

    tlb_set_array u_set_array (
        .CLK   (CLK),
        .nRST  (nRST),
        .index (sram_index),
        .wen   (sram_wen),
        .wmask (sram_wmask),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    // tag and ASID compare across the indexed set
    always_comb begin
        hit     = 1'b0;
        hit_pte = '0;
        for (int w = 0; w < mmu_pkg::TLB_WAYS; w++) begin
            if (sram_rdata[w].valid && sram_rdata[w].asid == satp.asid
                && sram_rdata[w].tag == req_vpn[mmu_pkg::VPN_BITS-1:mmu_pkg::SET_BITS]) begin
                hit     = 1'b1;
                hit_pte = sram_rdata[w].pte;
            end
        end
    end

    assign miss  = (state == mmu_pkg::LOOKUP) && !fence.fence && trans_on && any_req && !hit;
    assign check = (state == mmu_pkg::LOOKUP) && !fence.fence && trans_on && hit;

    page_perm_check u_perm_check (
        .check       (check),
        .access      (access),
        .pte         (hit_pte),
        .user_mode   (user_mode),
        .fault_load  (rsp.fault_load),
        .fault_store (rsp.fault_store),
        .fault_insn  (rsp.fault_insn)
    );

    assign rsp.busy  = (state != mmu_pkg::LOOKUP) || fence.fence || miss;
    assign rsp.paddr = trans_on ? {hit_pte.ppn, req.vaddr[mmu_pkg::PAGE_OFFSET_BITS-1:0]}
                                : {2'b00, req.vaddr};   // bare mode

    // fence rule, global pages survive an ASID fence
    assign sweep_entry = sram_rdata[sweep_idx.way_num];
    assign fence_match = sweep_entry.valid
        && (fence_va_q == '0
            || {sweep_entry.tag, sweep_idx.set_num} == fence_va_q[31:mmu_pkg::PAGE_OFFSET_BITS])
        && (fence_asid_q == '0
            || (sweep_entry.asid == fence_asid_q && !sweep_entry.pte.perms.global_page));

    always_comb begin
        fill_entry.valid = 1'b1;
        fill_entry.asid  = satp.asid;
        fill_entry.tag   = miss_vpn[mmu_pkg::VPN_BITS-1:mmu_pkg::SET_BITS];
        fill_entry.pte   = fill_pte;
    end

    always_comb begin
        sram_wen   = 1'b0;
        sram_wmask = '0;
        sram_wdata = '0;   // zero entry for clear and fence
        case (state)
            mmu_pkg::CLEAR: begin
                sram_wen                      = 1'b1;
                sram_wmask[sweep_idx.way_num] = 1'b1;
            end
            mmu_pkg::FENCE: begin
                sram_wen                      = fence_match;
                sram_wmask[sweep_idx.way_num] = 1'b1;
            end
            mmu_pkg::FILL: begin
                sram_wen                     = fill_valid;
                sram_wmask[victim[miss_set]] = 1'b1;
                for (int w = 0; w < mmu_pkg::TLB_WAYS; w++) begin
                    sram_wdata[w] = fill_entry;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            mmu_pkg::CLEAR:  if (sweep_last) next_state = mmu_pkg::LOOKUP;
            mmu_pkg::LOOKUP: begin
                if (fence.fence) next_state = mmu_pkg::FENCE;   // fence wins over req
                else if (miss)   next_state = mmu_pkg::FILL;
            end
            mmu_pkg::FILL:   if (fill_valid) next_state = mmu_pkg::LOOKUP;
            mmu_pkg::FENCE:  if (sweep_last) next_state = mmu_pkg::LOOKUP;
            default:         next_state = mmu_pkg::LOOKUP;
        endcase
    end

    assign fence_done = (state == mmu_pkg::FENCE) && sweep_last;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= mmu_pkg::CLEAR;
            sweep_idx   <= '0;
            fetch_start <= 1'b0;
            for (int s = 0; s < mmu_pkg::TLB_SETS; s++) begin
                victim[s] <= '0;
            end
        end else begin
            state       <= next_state;
            fetch_start <= miss;   // first FILL cycle
            if ((state == mmu_pkg::CLEAR || state == mmu_pkg::FENCE) && !sweep_last) begin
                sweep_idx <= mmu_pkg::sweep_idx_t'(sweep_idx + 1'b1);
            end else begin
                sweep_idx <= '0;
            end
            if (state == mmu_pkg::FILL && fill_valid) begin
                // round robin within the set
                if (victim[miss_set] == mmu_pkg::way_idx_t'(mmu_pkg::TLB_WAYS - 1)) begin
                    victim[miss_set] <= '0;
                end else begin
                    victim[miss_set] <= victim[miss_set] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (miss) begin
            miss_vpn <= req_vpn;
        end
        if (state == mmu_pkg::LOOKUP && fence.fence) begin
            fence_va_q   <= fence.va;
            fence_asid_q <= fence.asid;
        end
    end

    assign fetch_vpn = miss_vpn;

endmodule

`default_nettype wire

// File: tlb/tlb_set_array.sv
/*
 * TLB set array
 * one row per set holding every way, read combinationally,
 * written per way under a mask
 */
`timescale 1ns/1ps
`default_nettype none

module tlb_set_array (
    input  logic                          CLK,
    input  logic                          nRST,
    input  mmu_pkg::set_idx_t             index,
    input  logic                          wen,
    input  logic [mmu_pkg::TLB_WAYS-1:0]  wmask,
    input  mmu_pkg::tlb_set_t             wdata,
    output mmu_pkg::tlb_set_t             rdata
);

    mmu_pkg::tlb_set_t rows [mmu_pkg::TLB_SETS];

    assign rdata = rows[index];   // whole set, no read latency

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < mmu_pkg::TLB_SETS; s++) begin
                rows[s] <= '0;
            end
        end else if (wen) begin
            for (int w = 0; w < mmu_pkg::TLB_WAYS; w++) begin
                if (wmask[w]) begin
                    rows[index][w] <= wdata[w];   // untouched ways keep their entry
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/mmu_asserts.sv
/*
 * MMU protocol assertions
 * memory read stability under back-pressure, fence completion
 * pulse and busy after a PTE fetch starts
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_asserts (
    input logic            CLK,
    input logic            nRST,
    input logic            mem_ren,
    input logic            mem_busy,
    input mmu_pkg::paddr_t mem_addr,
    input logic            fence_done,
    input logic            fetch_start,
    input logic            busy
);

    int unsigned assert_fails = 0;

    // address held while the memory stalls
    mem_addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
        mem_ren && mem_busy |=> $stable(mem_addr))
        else begin
            assert_fails++;
            $error("mem_addr changed during a stalled PTE read");
        end

    fence_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        fence_done |=> !fence_done)
        else begin
            assert_fails++;
            $error("fence_done high for more than one cycle");
        end

    busy_after_fetch: assert property (@(posedge CLK) disable iff (!nRST)
        fetch_start |=> busy)   // walk still in flight
        else begin
            assert_fails++;
            $error("busy low in the cycle after fetch_start");
        end

endmodule

bind mmu_top mmu_asserts u_asserts (
    .CLK         (CLK),
    .nRST        (nRST),
    .mem_ren     (mem_ren),
    .mem_busy    (mem_busy),
    .mem_addr    (mem_addr),
    .fence_done  (fence_done),
    .fetch_start (fetch_start),
    .busy        (rsp.busy)
);

`default_nettype wire

// File: verification/mmu_tb.sv
/*
 * MMU testbench
 * seeded random requests, fences and memory back-pressure,
 * checked against a reference TLB and a flat page-table model
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

    localparam int PERIOD      = 4;
    localparam int SWEEP       = mmu_pkg::TLB_SETS * mmu_pkg::TLB_WAYS;
    localparam int N_RANDOM    = 240;
    localparam int N_REQS      = 64 + 16 + N_RANDOM + 32;
    localparam int N_FENCES    = N_RANDOM / 20;
    // worst access is 3 fill cycles, 3 busy cycles and 2 idle cycles
    localparam int WATCHDOG_NS = (N_REQS * 8 + N_FENCES * (SWEEP + 2) + 2 * SWEEP) * PERIOD * 2;

    logic                CLK = 1'b0;
    logic                nRST;
    mmu_pkg::tlb_req_t   req;
    mmu_pkg::satp_t      satp;
    logic                user_mode;
    mmu_pkg::fence_req_t fence;
    mmu_pkg::tlb_rsp_t   rsp;
    logic                fence_done;
    logic                mem_ren;
    mmu_pkg::paddr_t     mem_addr;
    mmu_pkg::word_t      mem_rdata;
    logic                mem_busy;

    integer        seed      = 91325;
    int            errors    = 0;
    int            checks    = 0;
    int            mem_reads = 0;
    int            busy_left = 0;
    int            last_busy = 0;
    logic          in_read   = 1'b0;
    mmu_pkg::vpn_t cur_vpn   = '0;   // page of the request in flight

    mmu_pkg::pte_t  page_table [64];
    logic           ref_valid  [mmu_pkg::TLB_SETS][mmu_pkg::TLB_WAYS];
    mmu_pkg::asid_t ref_asid   [mmu_pkg::TLB_SETS][mmu_pkg::TLB_WAYS];
    mmu_pkg::vpn_t  ref_vpn    [mmu_pkg::TLB_SETS][mmu_pkg::TLB_WAYS];
    mmu_pkg::pte_t  ref_pte    [mmu_pkg::TLB_SETS][mmu_pkg::TLB_WAYS];
    int             ref_victim [mmu_pkg::TLB_SETS];

    mmu_top uut (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (req),
        .satp       (satp),
        .user_mode  (user_mode),
        .fence      (fence),
        .rsp        (rsp),
        .fence_done (fence_done),
        .mem_ren    (mem_ren),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy)
    );

    initial begin
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the DUT stopped completing requests", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    task automatic expect_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // page-table memory, random stall then the leaf word
    task automatic serve_memory();
        mmu_pkg::paddr_t exp_addr;
        exp_addr = {satp.ppn, 12'h000} + mmu_pkg::paddr_t'(cur_vpn) * 4;
        if (mem_ren && !in_read) begin
            expect_eq(mem_addr, exp_addr, "PTE address");
            busy_left = $random(seed) & 3;
            last_busy = busy_left;
            in_read   = 1'b1;
            mem_reads++;
        end
        if (mem_ren && busy_left > 0) begin
            mem_busy  = 1'b1;
            mem_rdata = $random(seed);   // junk until ready
            busy_left--;
        end else begin
            mem_busy  = 1'b0;
            mem_rdata = page_table[cur_vpn[5:0]];
            in_read   = 1'b0;
        end
    endtask

    task automatic next_cycle();
        @(negedge CLK);
        serve_memory();
    endtask

    function automatic int find_way(input mmu_pkg::vpn_t vpn);
        int set_num;
        set_num  = vpn % mmu_pkg::TLB_SETS;
        find_way = -1;
        for (int w = 0; w < mmu_pkg::TLB_WAYS; w++) begin
            if (ref_valid[set_num][w] && ref_vpn[set_num][w] == vpn
                && ref_asid[set_num][w] == satp.asid) begin
                find_way = w;
            end
        end
    endfunction

    // {load, store, insn}
    function automatic logic [2:0] expected_faults(input mmu_pkg::pte_t p,
                                                   input mmu_pkg::access_t kind,
                                                   input logic umode);
        logic bad;
        bad = !p.perms.valid || (p.perms.writable && !p.perms.readable)
           || !p.perms.accessed || (umode != p.perms.user);
        case (kind)
            mmu_pkg::LOAD:  expected_faults = {bad || !p.perms.readable, 2'b00};
            mmu_pkg::STORE: expected_faults = {1'b0, bad || !p.perms.writable || !p.perms.dirty, 1'b0};
            default:        expected_faults = {2'b00, bad || !p.perms.executable};
        endcase
    endfunction

    task automatic issue_access(input mmu_pkg::word_t vaddr, input mmu_pkg::access_t kind,
                                input logic umode);
        mmu_pkg::vpn_t vpn;
        mmu_pkg::pte_t pte;
        int            set_num;
        int            way;
        int            waited;
        int            reads_before;
        logic          bare;
        logic          quick;
        vpn     = vaddr[31:12];
        set_num = vpn % mmu_pkg::TLB_SETS;
        bare    = !satp.mode;
        way     = bare ? -1 : find_way(vpn);
        quick   = bare || way >= 0;   // no walk expected
        pte     = (way >= 0) ? ref_pte[set_num][way] : page_table[vpn[5:0]];
        next_cycle();
        cur_vpn      = vpn;
        req.vaddr    = vaddr;
        req.ren      = (kind == mmu_pkg::LOAD);
        req.wen      = (kind == mmu_pkg::STORE);
        req.fetch    = (kind == mmu_pkg::INSN);
        user_mode    = umode;
        reads_before = mem_reads;
        waited       = 0;
        #1;
        while (rsp.busy && waited < 20) begin
            next_cycle();
            #1;
            waited++;
        end
        assert (!rsp.busy) else begin
            errors++;
            $display("request to %h stayed busy and never completed", vaddr);
        end
        expect_eq(mem_reads - reads_before, quick ? 0 : 1, "PTE reads");
        expect_eq(waited, quick ? 0 : 3 + last_busy, "response latency");
        expect_eq(rsp.paddr, bare ? {2'b00, vaddr} : {pte.ppn, vaddr[11:0]}, "paddr");
        expect_eq({rsp.fault_load, rsp.fault_store, rsp.fault_insn},
                  bare ? 3'b000 : expected_faults(pte, kind, umode), "fault flags");
        if (!quick) begin
            way                     = ref_victim[set_num];
            ref_valid[set_num][way] = 1'b1;
            ref_asid[set_num][way]  = satp.asid;
            ref_vpn[set_num][way]   = vpn;
            ref_pte[set_num][way]   = pte;
            ref_victim[set_num]     = (way + 1) % mmu_pkg::TLB_WAYS;
        end
        next_cycle();
        req.ren   = 1'b0;
        req.wen   = 1'b0;
        req.fetch = 1'b0;
    endtask

    task automatic run_fence(input mmu_pkg::word_t va, input mmu_pkg::asid_t asid);
        int cycles;
        next_cycle();
        fence.fence = 1'b1;
        fence.va    = va;
        fence.asid  = asid;
        #1;
        expect_eq(rsp.busy, 1, "busy on fence request");
        cycles = 0;
        do begin
            next_cycle();
            fence.fence = 1'b0;
            #1;
            cycles++;
            expect_eq(rsp.busy, 1, "busy during fence");
        end while (!fence_done && cycles < 4 * SWEEP);
        expect_eq(cycles, SWEEP, "fence sweep cycles");
        for (int s = 0; s < mmu_pkg::TLB_SETS; s++) begin
            for (int w = 0; w < mmu_pkg::TLB_WAYS; w++) begin
                if (ref_valid[s][w] && (va == 0 || ref_vpn[s][w] == va[31:12])
                    && (asid == 0 || (ref_asid[s][w] == asid
                                      && !ref_pte[s][w].perms.global_page))) begin
                    ref_valid[s][w] = 1'b0;
                end
            end
        end
    endtask

    initial begin
        logic [31:0]    r;
        mmu_pkg::word_t va;
        int             n;
        int             kind;
        int             pick;
        nRST      = 1'b0;
        req       = '0;
        satp      = '0;
        user_mode = 1'b0;
        fence     = '0;
        mem_rdata = '0;
        mem_busy  = 1'b0;
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            page_table[i].ppn                    = mmu_pkg::ppn_t'($random(seed));
            page_table[i].perms.reserved         = 2'b00;
            page_table[i].perms.valid            = r[2:0] != 0;   // mostly valid
            page_table[i].perms.accessed         = r[5:3] != 0;
            page_table[i].perms.dirty            = r[7:6] != 0;
            page_table[i].perms.readable         = r[9:8] != 0;
            page_table[i].perms.writable         = r[10];
            page_table[i].perms.executable       = r[11];
            page_table[i].perms.user             = r[12];
            page_table[i].perms.global_page      = r[14:13] == 0;
        end
        for (int s = 0; s < mmu_pkg::TLB_SETS; s++) begin
            ref_victim[s] = 0;
            for (int w = 0; w < mmu_pkg::TLB_WAYS; w++) ref_valid[s][w] = 1'b0;
        end
        satp.mode = 1'b1;
        satp.asid = 9'd5;
        satp.ppn  = mmu_pkg::ppn_t'($random(seed));

        @(negedge CLK);
        expect_eq({rsp.busy, mem_ren, fence_done}, 3'b100, "outputs in reset");
        @(negedge CLK);
        nRST = 1'b1;
        #1;
        n = 0;
        while (rsp.busy && n < 4 * SWEEP) begin   // clear sweep
            expect_eq({mem_ren, fence_done}, 2'b00, "mem_ren and fence_done in clear");
            next_cycle();
            #1;
            n++;
        end
        expect_eq(n, SWEEP, "clear sweep cycles");

        // first touch of every page walks the table
        for (int v = 0; v < 64; v++) begin
            va        = $random(seed);
            va[31:12] = v;
            issue_access(va, mmu_pkg::LOAD, 1'b0);
        end
        for (int v = 48; v < 64; v++) begin   // still resident
            va        = $random(seed);
            va[31:12] = v;
            kind      = ($random(seed) & 255) % 3;
            issue_access(va, mmu_pkg::access_t'(kind + 1), $random(seed) & 1);
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            if (i % 60 == 30) satp.asid = (satp.asid == 9'd5) ? 9'd9 : 9'd5;
            if (i % 20 == 10) begin
                pick      = $random(seed) & 3;   // bit 0 by VA, bit 1 by ASID
                va        = $random(seed);
                va[31:12] = $random(seed) & 63;
                run_fence(pick[0] ? va : 32'h0,
                          pick[1] ? ((($random(seed) & 1) != 0) ? 9'd5 : 9'd9) : 9'd0);
            end
            va        = $random(seed);
            va[31:12] = $random(seed) & 63;
            kind      = ($random(seed) & 255) % 3;
            issue_access(va, mmu_pkg::access_t'(kind + 1), $random(seed) & 1);
        end

        satp.mode = 1'b0;   // bare
        repeat (16) begin
            kind = ($random(seed) & 255) % 3;
            issue_access($random(seed), mmu_pkg::access_t'(kind + 1), $random(seed) & 1);
        end
        satp.mode = 1'b1;
        repeat (16) begin
            va        = $random(seed);
            va[31:12] = $random(seed) & 63;
            kind      = ($random(seed) & 255) % 3;
            issue_access(va, mmu_pkg::access_t'(kind + 1), $random(seed) & 1);
        end

        next_cycle();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.u_asserts.assert_fails);
        if (errors == 0 && uut.u_asserts.assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/mmu_top.sv
/*
 * Sv32 MMU top level
 * TLB in front of the PTE fetch unit,
 * which reads the external page-table memory
 */
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  mmu_pkg::tlb_req_t    req,
    input  mmu_pkg::satp_t       satp,
    input  logic                 user_mode,
    input  mmu_pkg::fence_req_t  fence,
    output mmu_pkg::tlb_rsp_t    rsp,
    output logic                 fence_done,
    output logic                 mem_ren,
    output mmu_pkg::paddr_t      mem_addr,
    input  mmu_pkg::word_t       mem_rdata,
    input  logic                 mem_busy
);

    logic           fetch_start;
    mmu_pkg::vpn_t  fetch_vpn;
    logic           fill_valid;
    mmu_pkg::pte_t  fill_pte;

    tlb u_tlb (
        .CLK         (CLK),
        .nRST        (nRST),
        .req         (req),
        .satp        (satp),
        .user_mode   (user_mode),
        .fence       (fence),
        .fill_valid  (fill_valid),
        .fill_pte    (fill_pte),
        .rsp         (rsp),
        .fence_done  (fence_done),
        .fetch_start (fetch_start),
        .fetch_vpn   (fetch_vpn)
    );

    pte_fetch u_pte_fetch (
        .CLK         (CLK),
        .nRST        (nRST),
        .fetch_start (fetch_start),
        .fetch_vpn   (fetch_vpn),
        .root_ppn    (satp.ppn),   // flat leaf table base
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .mem_ren     (mem_ren),
        .mem_addr    (mem_addr),
        .fill_valid  (fill_valid),
        .fill_pte    (fill_pte)
    );

endmodule

`default_nettype wire

// File: verilog/page_perm_check.sv
/*
 * Sv32 leaf permission check
 * evaluates a PTE against the access type and privilege
 * and raises the matching page fault
 */
`timescale 1ns/1ps
`default_nettype none

module page_perm_check (
    input  logic              check,
    input  mmu_pkg::access_t  access,
    input  mmu_pkg::pte_t     pte,
    input  logic              user_mode,
    output logic              fault_load,
    output logic              fault_store,
    output logic              fault_insn
);

    logic base_fault;
    logic priv_fault;

    // faults common to every access type
    assign base_fault = !pte.perms.valid
                     || (pte.perms.writable && !pte.perms.readable)   // reserved encoding
                     || !pte.perms.accessed;                          // no A update in hw

    assign priv_fault = (user_mode != pte.perms.user);   // U pages only from user mode

    always_comb begin
        fault_load  = 1'b0;
        fault_store = 1'b0;
        fault_insn  = 1'b0;
        if (check) begin
            case (access)
                mmu_pkg::LOAD: begin
                    fault_load = base_fault || priv_fault || !pte.perms.readable;
                end
                mmu_pkg::STORE: begin
                    // clear D on a store faults, no D update either
                    fault_store = base_fault || priv_fault
                               || !pte.perms.writable || !pte.perms.dirty;
                end
                mmu_pkg::INSN: begin
                    fault_insn = base_fault || priv_fault || !pte.perms.executable;
                end
                default: ;   // no access, nothing to flag
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/pte_fetch.sv
/*
 * PTE fetch unit
 * reads the leaf PTE of a missed VPN from the flat page table
 * and hands it back to the TLB as a fill
 */
`timescale 1ns/1ps
`default_nettype none

module pte_fetch (
    input  logic                   CLK,
    input  logic                   nRST,
    input  logic                   fetch_start,
    input  mmu_pkg::vpn_t          fetch_vpn,
    input  mmu_pkg::ppn_t          root_ppn,
    input  mmu_pkg::word_t         mem_rdata,
    input  logic                   mem_busy,
    output logic                   mem_ren,
    output mmu_pkg::paddr_t        mem_addr,
    output logic                   fill_valid,
    output mmu_pkg::pte_t          fill_pte
);

    mmu_pkg::fetch_state_t state;
    mmu_pkg::paddr_t       pte_addr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= mmu_pkg::IDLE;
        end else begin
            case (state)
                mmu_pkg::IDLE: if (fetch_start) state <= mmu_pkg::READ;
                mmu_pkg::READ: if (!mem_busy) state <= mmu_pkg::IDLE;   // data taken
                default:       state <= mmu_pkg::IDLE;
            endcase
        end
    end

    // root * 4096 + vpn * 4, one word per leaf
    always_ff @(posedge CLK) begin
        if (state == mmu_pkg::IDLE && fetch_start) begin
            pte_addr <= {root_ppn, 12'b0} + {12'b0, fetch_vpn, 2'b00};
        end
    end

    assign mem_ren  = (state == mmu_pkg::READ);   // held through back-pressure
    assign mem_addr = pte_addr;

    // memory word valid on the edge that sees busy low
    assign fill_valid = (state == mmu_pkg::READ) && !mem_busy;
    assign fill_pte   = mmu_pkg::pte_t'(mem_rdata);

endmodule

`default_nettype wire

// File: vlog.f
common/mmu_pkg.sv
tlb/tlb_set_array.sv
verilog/page_perm_check.sv
tlb/tlb.sv
verilog/pte_fetch.sv
verilog/mmu_top.sv
verification/mmu_asserts.sv
verification/mmu_tb.sv
